// File: pad_pkg.sv
// Host-side gamepad and mouse types shared by the controller port logic
package pad_pkg;

	// ==================================================================
	// Host gamepad word
	// ==================================================================

	localparam int NUM_PADS = 5;   // Host pads behind the multitap
	localparam int PAD_W    = 12;

	// Button bit positions within pad_bits_t
	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_I      = 4;
	localparam int BTN_II     = 5;
	localparam int BTN_SELECT = 6;
	localparam int BTN_RUN    = 7;
	localparam int BTN_III    = 8;  // Six-button extras from here up
	localparam int BTN_IV     = 9;
	localparam int BTN_V      = 10;
	localparam int BTN_VI     = 11;

	typedef logic [PAD_W-1:0] pad_bits_t;  // Active-high, one bit per button

	// Run-time options from the host menu
	typedef struct packed {
		logic joy_swap;  // Exchange pads 0 and 1
		logic turbotap;  // Five-port multitap
		logic buttons6;  // Six-button pads
		logic mouse_en;  // Mouse replaces pad on port 0
	} pad_cfg_t;

	// ==================================================================
	// Host mouse
	// ==================================================================

	localparam int MOUSE_D_W = 8;

	typedef struct packed {
		logic                 strobe;  // One-cycle pulse, deltas valid
		logic [MOUSE_D_W-1:0] dx;
		logic [MOUSE_D_W-1:0] dy;
		logic                 btn_l;
		logic                 btn_r;
	} mouse_evt_t;

endpackage

// File: port_pkg.sv
// Console-side controller port protocol types and constants
package port_pkg;

	// ==================================================================
	// Port lines and data word
	// ==================================================================

	localparam int NIBBLE_W    = 4;
	localparam int NUM_NIBBLES = 4;  // Nibbles per port word

	// Select and clear as driven by the console
	typedef struct packed {
		logic clr;
		logic sel;
	} port_ctrl_t;

	// Active-low port word, indexed by nibble
	// Nibble 0 and 1 are the base pad, 2 and 3 the six-button extras
	typedef logic [NUM_NIBBLES-1:0][NIBBLE_W-1:0] port_word_t;

	typedef logic [2:0] port_idx_t;    // Multitap port 0 to 7
	typedef logic [1:0] mouse_phase_t; // Which delta nibble is shown

	// Ports 5 to 7 answer with no pad attached
	localparam port_word_t IDLE_WORD = 16'h0FFF;

	// ==================================================================
	// Mouse resync
	// ==================================================================

	// Counter saturates after 32767 cycles with clear low
	localparam int MOUSE_TIMEOUT_W = 15;

endpackage

// File: pad_decode.sv
// Pad remap and port multiplexer, host buttons to console active-low words
`timescale 1ns/1ps

module pad_decode
	import pad_pkg::*;
	import port_pkg::*;
(
	input  pad_bits_t           pads [NUM_PADS],
	input  pad_cfg_t            cfg,
	input  port_idx_t           port_idx,
	input  logic [NIBBLE_W-1:0] mouse_nibble,  // Delta nibble from tracker
	input  logic [1:0]          mouse_btn,     // {left, right}
	output port_word_t          port_word
);

	// ==================================================================
	// Remap
	// ==================================================================

	// Host pad bits to the console's nibble layout, then inverted
	function automatic port_word_t remap(pad_bits_t p);
		port_word_t w;
		w[0] = {p[BTN_RUN], p[BTN_SELECT], p[BTN_II], p[BTN_I]};
		w[1] = {p[BTN_LEFT], p[BTN_DOWN], p[BTN_RIGHT], p[BTN_UP]};
		w[2] = {p[BTN_VI], p[BTN_V], p[BTN_IV], p[BTN_III]};
		w[3] = '1;  // Six-button signature reads as zero
		return ~w;
	endfunction

	pad_bits_t pad_0;  // After swap
	pad_bits_t pad_1;

	logic [2*NIBBLE_W-1:0] mouse_byte;

	always_comb begin
		pad_0 = cfg.joy_swap ? pads[1] : pads[0];
		pad_1 = cfg.joy_swap ? pads[0] : pads[1];
	end

	// Mouse buttons share the low nibble with run and select of pad 0
	always_comb begin
		mouse_byte[NIBBLE_W-1:0] = ~{pad_0[BTN_RUN], pad_0[BTN_SELECT], mouse_btn};
		mouse_byte[2*NIBBLE_W-1:NIBBLE_W] = mouse_nibble;
	end

	// ==================================================================
	// Port select
	// ==================================================================

	always_comb begin
		case (port_idx)
			3'd0: begin
				if (cfg.mouse_en) begin
					port_word = {mouse_byte, mouse_byte};
				end else begin
					port_word = remap(pad_0);
				end
			end
			3'd1: port_word = remap(pad_1);
			3'd2: port_word = remap(pads[2]);
			3'd3: port_word = remap(pads[3]);
			3'd4: port_word = remap(pads[4]);
			default: port_word = IDLE_WORD;  // Empty multitap ports
		endcase
	end

endmodule

// File: mouse_tracker.sv
// Mouse delta capture and nibble sequencing over console clear cycles
`timescale 1ns/1ps

module mouse_tracker
	import pad_pkg::*;
	import port_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst_n,
	input  mouse_evt_t          mouse,
	input  port_ctrl_t          ctrl,
	output logic [NIBBLE_W-1:0] mouse_nibble
);

	logic clr_q;
	logic clr_rise;

	mouse_phase_t               phase;
	logic [MOUSE_TIMEOUT_W-1:0] timeout_cnt;
	logic                       timeout_hit;

	logic [MOUSE_D_W-1:0] stage_x;  // Collected since last readout
	logic [MOUSE_D_W-1:0] stage_y;
	logic [MOUSE_D_W-1:0] shown_x;  // Being read by the console
	logic [MOUSE_D_W-1:0] shown_y;

	assign clr_rise    = ctrl.clr & ~clr_q;
	assign timeout_hit = &timeout_cnt;

	// ==================================================================
	// Phase, timeout and delta registers
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			clr_q       <= 1'b0;
			phase       <= 2'd3;
			timeout_cnt <= '0;
			stage_x     <= '0;
			stage_y     <= '0;
			shown_x     <= '0;
			shown_y     <= '0;
		end else begin
			clr_q <= ctrl.clr;

			// Console idle too long, restart at x high nibble
			if (ctrl.clr) begin
				timeout_cnt <= '0;
			end else if (!timeout_hit) begin
				timeout_cnt <= timeout_cnt + 1'b1;
			end
			if (timeout_hit) phase <= 2'd3;

			if (clr_rise) begin
				phase <= phase + 1'b1;
				if (&phase) begin  // New readout begins
					shown_x <= stage_x;
					shown_y <= stage_y;
					stage_x <= '0;
					stage_y <= '0;
				end
			end

			// X axis runs the other way on the console
			if (mouse.strobe) begin
				stage_x <= 8'd0 - mouse.dx;
				stage_y <= mouse.dy;
			end
		end
	end

	always_comb begin
		case (phase)
			2'd0: mouse_nibble = shown_x[7:4];
			2'd1: mouse_nibble = shown_x[3:0];
			2'd2: mouse_nibble = shown_y[7:4];
			default: mouse_nibble = shown_y[3:0];
		endcase
	end

	// Saturated timeout resyncs the phase unless a clear edge takes over
	a_timeout_resync: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(timeout_hit && !ctrl.clr) |=> (phase == 2'd3)
	) else $error("mouse phase not resynced after timeout");

endmodule

// File: port_sequencer.sv
// Console port sequencer, follows select and clear and latches the nibble
`timescale 1ns/1ps

module port_sequencer
	import pad_pkg::*;
	import port_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst_n,
	input  port_ctrl_t          ctrl,
	input  pad_cfg_t            cfg,
	input  port_word_t          port_word,
	output port_idx_t           port_idx,
	output logic [NIBBLE_W-1:0] joy_in
);

	logic sel_q;  // Previous line levels
	logic clr_q;
	logic sel_rise;
	logic clr_rise;

	logic high_buttons;  // Six-button phase, extras on nibbles 2 and 3

	logic [NIBBLE_W-1:0] joy_latch;

	assign sel_rise = ctrl.sel & ~sel_q;
	assign clr_rise = ctrl.clr & ~clr_q;

	// ==================================================================
	// Port index, phase and output latch
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sel_q        <= 1'b0;
			clr_q        <= 1'b0;
			high_buttons <= 1'b0;
			port_idx     <= '0;
			joy_latch    <= '0;
		end else begin
			sel_q <= ctrl.sel;
			clr_q <= ctrl.clr;

			// Nibble from the word of the port held before this edge
			joy_latch <= port_word[{high_buttons, ctrl.sel}];

			if (ctrl.clr) begin
				port_idx  <= '0;
				joy_latch <= '0;
				// Alternate clear cycles show the extra buttons
				if (clr_rise) high_buttons <= ~high_buttons & cfg.buttons6;
			end else if (sel_rise && cfg.turbotap) begin
				port_idx <= port_idx + 1'b1;  // Next multitap port
			end
		end
	end

	assign joy_in = joy_latch;

	// ==================================================================
	// Checks
	// ==================================================================

	// Clear held at an edge always reads back as zero
	a_clear_zero: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ctrl.clr |=> (joy_in == '0)
	) else $error("joy_in not zero after clear");

	// Decoded word from pad_decode stays known once out of reset
	a_word_known: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!$isunknown(port_word)
	) else $error("port_word unknown");

endmodule

// File: pce_pad_top.sv
// Controller port top level, host pads and mouse to the console port nibble
`timescale 1ns/1ps

module pce_pad_top
	import pad_pkg::*;
	import port_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst_n,
	input  pad_bits_t           pads [NUM_PADS],
	input  pad_cfg_t            cfg,
	input  mouse_evt_t          mouse,
	input  port_ctrl_t          ctrl,
	output logic [NIBBLE_W-1:0] joy_in
);

	port_idx_t           port_idx;
	port_word_t          port_word;
	logic [NIBBLE_W-1:0] mouse_nibble;

	// ==================================================================
	// Decode, mouse tracking and port sequencing
	// ==================================================================

	pad_decode i_pad_decode (
		.pads         (pads),
		.cfg          (cfg),
		.port_idx     (port_idx),
		.mouse_nibble (mouse_nibble),
		.mouse_btn    ({mouse.btn_l, mouse.btn_r}),
		.port_word    (port_word)
	);

	mouse_tracker i_mouse_tracker (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.mouse        (mouse),
		.ctrl         (ctrl),
		.mouse_nibble (mouse_nibble)
	);

	port_sequencer i_port_sequencer (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.cfg       (cfg),
		.port_word (port_word),
		.port_idx  (port_idx),
		.joy_in    (joy_in)   // Registered, one cycle
	);

endmodule

// File: tb_pce_pad_top.sv
// Testbench for the controller port top level, models pads, multitap and mouse readout
`timescale 1ns/1ps

module tb_pce_pad_top
	import pad_pkg::*;
	import port_pkg::*;
();

	localparam int WATCHDOG_NS = 2_000_000;
	localparam int IDLE_CYCLES = 32800;  // Past the mouse resync point

	logic       clk_sys;
	logic       rst_n;
	pad_bits_t  pads [NUM_PADS];
	pad_cfg_t   cfg;
	mouse_evt_t mouse;
	port_ctrl_t ctrl;
	logic [3:0] joy_in;

	int checks;
	int errors;
	int sva_errors;
	int test_err0;
	logic [31:0] lfsr;

	// Reference model state
	logic [2:0] m_idx;
	logic       m_high;
	logic [1:0] m_phase;
	logic [7:0] m_stage_x;
	logic [7:0] m_stage_y;
	logic [7:0] m_shown_x;
	logic [7:0] m_shown_y;
	logic       prev_clr;
	logic       prev_sel;

	pce_pad_top i_pce_pad_top (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.pads    (pads),
		.cfg     (cfg),
		.mouse   (mouse),
		.ctrl    (ctrl),
		.joy_in  (joy_in)
	);

	always #5 clk_sys = ~clk_sys;

	// Console reads zero whenever clear was seen high
	a_clear_reads_zero: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ctrl.clr |=> (joy_in == 4'h0)
	) else begin
		sva_errors++;
		$display("[ERROR] joy_in: expected 0x0, got 0x%h with clear high", joy_in);
	end

	// ==================================================================
	// Stimulus and reference model
	// ==================================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic new_pads();
		logic [31:0] v;
		for (int i = 0; i < NUM_PADS; i++) begin
			rand_bits(12, v);
			pads[i] = v[11:0];
		end
	endtask

	// Console word for one host pad, active low
	function automatic logic [15:0] pad_word(input logic [11:0] p);
		return ~{4'hF, p[11], p[10], p[9], p[8], p[1], p[2], p[0], p[3],
			p[7], p[6], p[5], p[4]};
	endfunction

	function automatic logic [15:0] exp_word(input logic [2:0] idx);
		logic [11:0] p0;
		logic [11:0] p1;
		logic [3:0]  mn;
		logic [7:0]  mb;
		logic [15:0] w;
		p0 = cfg.joy_swap ? pads[1] : pads[0];
		p1 = cfg.joy_swap ? pads[0] : pads[1];
		case (m_phase)
			2'd0: mn = m_shown_x[7:4];
			2'd1: mn = m_shown_x[3:0];
			2'd2: mn = m_shown_y[7:4];
			default: mn = m_shown_y[3:0];
		endcase
		mb = {mn, ~{p0[7], p0[6], mouse.btn_l, mouse.btn_r}};
		case (idx)
			3'd0: w = cfg.mouse_en ? {mb, mb} : pad_word(p0);
			3'd1: w = pad_word(p1);
			3'd2: w = pad_word(pads[2]);
			3'd3: w = pad_word(pads[3]);
			3'd4: w = pad_word(pads[4]);
			default: w = 16'h0FFF;
		endcase
		return w;
	endfunction

	// Drive the port lines and step the model the way the console sees it
	task automatic drive_ctrl(input logic clr, input logic sel);
		ctrl.clr = clr;
		ctrl.sel = sel;
		if (clr) begin
			if (!prev_clr) begin
				m_high = cfg.buttons6 ? ~m_high : 1'b0;
				if (m_phase == 2'd3) begin
					m_shown_x = m_stage_x;
					m_shown_y = m_stage_y;
					m_stage_x = 8'h00;
					m_stage_y = 8'h00;
				end
				m_phase = m_phase + 2'd1;
			end
			m_idx = 3'd0;
		end else if (sel && !prev_sel && cfg.turbotap) begin
			m_idx = m_idx + 3'd1;
		end
		prev_clr = clr;
		prev_sel = sel;
	endtask

	task automatic check_out();
		logic [15:0] w;
		logic [3:0]  exp;
		w = exp_word(m_idx);
		exp = ctrl.clr ? 4'h0 : w[{m_high, ctrl.sel, 2'b00} +: 4];
		checks++;
		assert (joy_in === exp) else begin
			errors++;
			$display("[ERROR] joy_in: expected 0x%h, got 0x%h (port %0d, sel %0b)",
				exp, joy_in, m_idx, ctrl.sel);
		end
	endtask

	// Two rising edges pass before the sample, taken on a falling edge
	task automatic apply(input logic clr, input logic sel);
		drive_ctrl(clr, sel);
		repeat (2) @(negedge clk_sys);
		check_out();
	endtask

	task automatic clear_pulse();
		apply(1'b1, 1'b0);
		apply(1'b0, 1'b0);
	endtask

	task automatic strobe_mouse(input logic [7:0] dx, input logic [7:0] dy);
		mouse.strobe = 1'b1;
		mouse.dx = dx;
		mouse.dy = dy;
		@(negedge clk_sys);
		mouse.strobe = 1'b0;
		m_stage_x = 8'd0 - dx;
		m_stage_y = dy;
	endtask

	task automatic wait_joy_zero(input int max_cycles);
		int n;
		n = 0;
		while (joy_in !== 4'h0 && n < max_cycles) begin
			@(negedge clk_sys);
			n++;
		end
		if (joy_in !== 4'h0) begin
			errors++;
			$display("joy_in did not drop to zero while clear was held");
		end
	endtask

	task automatic end_test(input string name);
		int total;
		total = errors + sva_errors;
		$display("%s done, %0d errors", name, total - test_err0);
		test_err0 = total;
	endtask

	// ==================================================================
	// Test sequence
	// ==================================================================

	initial begin
		#WATCHDOG_NS;
		$display("Simulation ran past its time limit");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		clk_sys = 1'b0;
		rst_n = 1'b0;
		cfg = '0;
		mouse = '0;
		ctrl = '0;
		for (int i = 0; i < NUM_PADS; i++) pads[i] = '0;
		checks = 0;
		errors = 0;
		sva_errors = 0;
		test_err0 = 0;
		lfsr = 32'h7ffa;
		m_idx = 3'd0;  // Reset state of the DUT
		m_high = 1'b0;
		m_phase = 2'd3;
		m_stage_x = 8'h00;
		m_stage_y = 8'h00;
		m_shown_x = 8'h00;
		m_shown_y = 8'h00;
		prev_clr = 1'b0;
		prev_sel = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		for (int r = 0; r < 8; r++) begin
			cfg.joy_swap = (r >= 4);  // Second half reads the swapped pad
			new_pads();
			clear_pulse();
			apply(1'b0, 1'b1);
		end
		end_test("basic_pad");

		cfg = '0;
		cfg.turbotap = 1'b1;
		clear_pulse();
		apply(1'b0, 1'b1);
		apply(1'b0, 1'b0);
		apply(1'b0, 1'b1);  // Port 2 now
		drive_ctrl(1'b1, 1'b1);
		wait_joy_zero(4);
		apply(1'b1, 1'b0);
		apply(1'b0, 1'b0);  // Back on port 0
		end_test("clear");

		for (int r = 0; r < 2; r++) begin
			new_pads();
			clear_pulse();
			for (int p = 1; p < 8; p++) begin
				apply(1'b0, 1'b1);
				apply(1'b0, 1'b0);
			end
		end
		end_test("multitap");

		cfg = '0;
		cfg.buttons6 = 1'b1;
		for (int r = 0; r < 4; r++) begin
			new_pads();
			clear_pulse();  // Extras on every second clear cycle
			apply(1'b0, 1'b1);
		end
		end_test("six_button");

		cfg = '0;
		cfg.mouse_en = 1'b1;
		new_pads();
		mouse.btn_l = 1'b1;
		for (int k = 0; k < 4 && m_phase != 2'd3; k++) clear_pulse();
		strobe_mouse(8'h35, 8'h96);
		clear_pulse();
		for (int k = 0; k < 4; k++) begin
			apply(1'b0, 1'b1);
			apply(1'b0, 1'b0);
			clear_pulse();
		end
		end_test("mouse");

		clear_pulse();
		strobe_mouse(8'h5a, 8'h21);
		for (int i = 0; i < IDLE_CYCLES; i++) @(negedge clk_sys);
		m_phase = 2'd3;  // Resync after the long idle
		clear_pulse();
		apply(1'b0, 1'b1);
		clear_pulse();
		apply(1'b0, 1'b1);
		end_test("mouse_timeout");

		$display("Checks: %0d, errors: %0d", checks, errors + sva_errors);
		if (errors + sva_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
pad_pkg.sv
port_pkg.sv
pad_decode.sv
mouse_tracker.sv
port_sequencer.sv
pce_pad_top.sv
tb_pce_pad_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pce_pad_top
SIM_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(SIM_DIR)
	@out=$$(./$(SIM_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(SIM_DIR)
